//--- axi_lsu.f
design/axi_bus_pkg.sv
design/lsu_core_pkg.sv
design/lsu_thread_slots.sv
design/lsu_write_engine.sv
design/lsu_read_engine.sv
design/lsu_load_format.sv
design/axi_lsu.sv
tests/axi_lsu_asserts.sv
tests/axi_lsu_tb.sv

//--- Makefile
# Verilator build and run for the AXI load/store unit testbench

VERILATOR ?= verilator
TOP       ?= axi_lsu_tb
FILELIST  ?= axi_lsu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/axi_lsu_tb.sv
//==========================================================================
// Testbench of the AXI load/store unit
// Drives core requests against a sparse AXI slave memory model and checks
// the bus beats, the stall release and the formatted load returns
//==========================================================================

`timescale 1ns/1ps

module axi_lsu_tb;

  localparam int SLICE_OFFSET = 2;
  localparam int TIMEOUT = 5000;
  localparam logic [31:0] SEED = 32'he224_2b2f;

  logic        CLK = 1'b0;
  logic        RST = 1'b1;
  logic [1:0]  slice = '0;
  logic        req_cs = 1'b0;
  logic        req_wr = 1'b0;
  logic [31:0] req_addr = '0;
  logic [3:0]  req_mask = '0;
  logic [31:0] req_data = '0;
  logic [2:0]  req_sel = '0;
  logic        AWREADY = 1'b0;
  logic        WREADY = 1'b0;
  logic [1:0]  BID = '0;
  logic        BVALID = 1'b0;
  logic        ARREADY = 1'b0;
  logic [1:0]  RID = '0;
  logic [63:0] RDATA = '0;
  logic        RLAST = 1'b0;
  logic        RVALID = 1'b0;

  logic [3:0]  stall;
  logic        load_vld;
  logic [1:0]  load_slice;
  logic [2:0]  load_sel;
  logic [31:0] load_data;
  logic [1:0]  AWID, WID, ARID;
  logic [31:0] AWADDR, ARADDR;
  logic [3:0]  AWLEN, ARLEN;
  logic [2:0]  AWSIZE, ARSIZE;
  logic [1:0]  AWBURST, ARBURST;
  logic        AWVALID, WVALID, WLAST, BREADY, ARVALID, RREADY;
  logic [63:0] WDATA;
  logic [7:0]  WSTRB;

  // Slave model state
  logic [63:0] sim_mem [logic [28:0]];
  logic [31:0] ref_mem [logic [29:0]];
  logic [31:0] s_aw_addr [$];
  logic [1:0]  b_ids [$];
  logic [1:0]  r_ids [$];
  logic [31:0] r_addrs [$];
  int          s_idx;
  int          ready_pct = 100;
  int          hold_count = 1;
  logic        reverse_order = 1'b0;
  logic        release_resp = 1'b0;

  // Bus and load monitor queues
  logic [1:0]  aw_id_q [$];
  logic [31:0] aw_addr_q [$];
  logic [63:0] w_data_q [$];
  logic [7:0]  w_strb_q [$];
  logic [1:0]  ld_slice_q [$];
  logic [2:0]  ld_sel_q [$];
  logic [31:0] ld_data_q [$];
  logic [2:0]  exp_sel [4];
  logic [31:0] exp_data [4];
  logic [3:0]  mask_set [7] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf};

  axi_lsu #(.SLICE_OFFSET(SLICE_OFFSET)) uut (.*);

  initial
  begin
    forever #5 CLK = ~CLK;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got == exp)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // An unwritten aligned word holds its own byte address scrambled
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [63:0] mem_read(input logic [31:0] a);
    if (sim_mem.exists(a[31:3]))
      return sim_mem[a[31:3]];
    return {fill_word({a[31:3], 3'b100}), fill_word({a[31:3], 3'b000})};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    if (ref_mem.exists(a[31:2]))
      return ref_mem[a[31:2]];
    return fill_word({a[31:2], 2'b00});
  endfunction

  task automatic ref_store(input logic [31:0] a, input logic [3:0] m, input logic [31:0] d);
    logic [31:0] w;
    w = ref_read(a);
    for (int i = 0; i < 4; i++)
      if (m[i])
        w[8*i +: 8] = d[8*i +: 8];
    ref_mem[a[31:2]] = w;
  endtask

  // Field width from the mask, shifted down from its lowest byte
  function automatic logic [31:0] extract_field(input logic [31:0] w, input logic [3:0] m);
    int lo;
    lo = 0;
    while (lo < 3 && !m[lo])
      lo++;
    if ($countones(m) == 1)
      return (w >> (8 * lo)) & 32'h0000_00ff;
    if (m == 4'b0011 || m == 4'b1100)
      return (w >> (8 * lo)) & 32'h0000_ffff;
    return w;
  endfunction

  function automatic logic ready_draw();
    return int'($urandom_range(99, 0)) < ready_pct;
  endfunction

  // AXI slave with strobed writes, OKAY responses and a response policy
  always @(posedge CLK)
  begin
    if (RST)
    begin
      AWREADY <= 1'b0;
      WREADY  <= 1'b0;
      ARREADY <= 1'b0;
      BVALID  <= 1'b0;
      RVALID  <= 1'b0;
      RLAST   <= 1'b0;
    end
    else
    begin
      AWREADY <= ready_draw();
      WREADY  <= ready_draw();
      ARREADY <= ready_draw();
      if (AWVALID && AWREADY)
        s_aw_addr.push_back(AWADDR);
      if (WVALID && WREADY)
      begin
        sim_mem[s_aw_addr[0][31:3]] = mem_read(s_aw_addr[0]);
        for (int j = 0; j < 8; j++)
          if (WSTRB[j])
            sim_mem[s_aw_addr[0][31:3]][8*j +: 8] = WDATA[8*j +: 8];
        void'(s_aw_addr.pop_front());
        b_ids.push_back(WID);
      end
      if (ARVALID && ARREADY)
      begin
        r_ids.push_back(ARID);
        r_addrs.push_back(ARADDR);
      end
      if (b_ids.size() + r_ids.size() >= hold_count)
        release_resp = 1'b1;
      BVALID <= 1'b0;
      RVALID <= 1'b0;
      RLAST  <= 1'b0;
      if (release_resp && b_ids.size() > 0 && ready_draw())
      begin
        s_idx = 0;
        if (reverse_order)
          for (int i = 1; i < b_ids.size(); i++)
            if (b_ids[i] > b_ids[s_idx])
              s_idx = i;
        BID    <= b_ids[s_idx];
        BVALID <= 1'b1;
        b_ids.delete(s_idx);
      end
      if (release_resp && r_ids.size() > 0 && ready_draw())
      begin
        s_idx = 0;
        if (reverse_order)
          for (int i = 1; i < r_ids.size(); i++)
            if (r_ids[i] > r_ids[s_idx])
              s_idx = i;
        RID    <= r_ids[s_idx];
        RDATA  <= mem_read(r_addrs[s_idx]);
        RVALID <= 1'b1;
        RLAST  <= 1'b1;
        r_ids.delete(s_idx);
        r_addrs.delete(s_idx);
      end
      if (b_ids.size() == 0 && r_ids.size() == 0)
        release_resp = 1'b0;
    end
  end

  // Valid and ready are both settled at the falling edge
  always @(negedge CLK)
  begin
    if (!RST)
    begin
      if (AWVALID && AWREADY)
      begin
        aw_id_q.push_back(AWID);
        aw_addr_q.push_back(AWADDR);
      end
      if (WVALID && WREADY)
      begin
        w_data_q.push_back(WDATA);
        w_strb_q.push_back(WSTRB);
      end
      if (load_vld)
      begin
        ld_slice_q.push_back(load_slice);
        ld_sel_q.push_back(load_sel);
        ld_data_q.push_back(load_data);
      end
    end
  end

  task automatic issue(input logic [1:0] thr, input logic wr, input logic [31:0] addr,
                       input logic [3:0] mask, input logic [31:0] data,
                       input logic [2:0] sel);
    @(posedge CLK);
    slice    <= thr - 2'(SLICE_OFFSET);
    req_cs   <= 1'b1;
    req_wr   <= wr;
    req_addr <= addr;
    req_mask <= mask;
    req_data <= data;
    req_sel  <= sel;
    if (wr)
      ref_store(addr, mask, data);
    else
    begin
      exp_sel[thr]  = sel;
      exp_data[thr] = extract_field(ref_read(addr), mask);
    end
  endtask

  task automatic idle();
    @(posedge CLK);
    req_cs <= 1'b0;
  endtask

  // Each thread's stall has to be seen high and then low again
  task automatic wait_release(input logic [3:0] m);
    logic [3:0] seen;
    int n;
    seen = '0;
    for (n = 0; n < TIMEOUT; n++)
    begin
      @(negedge CLK);
      seen = seen | (stall & m);
      if (seen == m && (stall & m) == 4'b0)
        break;
    end
    assert (n < TIMEOUT)
    else
    begin
      $display("Timeout waiting for the stall of the requesting threads to clear");
      stop_run();
    end
  endtask

  task automatic wait_loads(input int cnt);
    int n;
    for (n = 0; n < TIMEOUT; n++)
    begin
      @(negedge CLK);
      if (ld_slice_q.size() >= cnt)
        break;
    end
    assert (n < TIMEOUT)
    else
    begin
      $display("Timeout waiting for load returns to the register file");
      stop_run();
    end
  endtask

  task automatic check_load(input logic [1:0] thr);
    int k;
    k = -1;
    for (int i = 0; i < ld_slice_q.size(); i++)
      if (ld_slice_q[i] == thr)
        k = i;
    assert (k >= 0)
    else
    begin
      $display("No load was returned for thread %0d", thr);
      stop_run();
    end
    assert (ld_sel_q[k] == exp_sel[thr])
    else
    begin
      $display("Mismatch load_sel: got %h, expected %h", ld_sel_q[k], exp_sel[thr]);
      stop_run();
    end
    assert (ld_data_q[k] == exp_data[thr])
    else
    begin
      $display("Mismatch load_data: got %h, expected %h", ld_data_q[k], exp_data[thr]);
      stop_run();
    end
    ld_slice_q.delete(k);
    ld_sel_q.delete(k);
    ld_data_q.delete(k);
  endtask

  task automatic test_reset();
    repeat (4)
    begin
      @(negedge CLK);
      assert (stall == 4'b0 && !AWVALID && !WVALID && !ARVALID && !load_vld)
      else
      begin
        $display("Outputs were not idle after reset");
        stop_run();
      end
    end
    // Every transfer is a single 4-byte beat in a fixed burst and every
    // response is taken at once
    check_value("AWLEN", 64'(AWLEN), 64'h0);
    check_value("AWSIZE", 64'(AWSIZE), 64'h2);
    check_value("AWBURST", 64'(AWBURST), 64'h0);
    check_value("ARLEN", 64'(ARLEN), 64'h0);
    check_value("ARSIZE", 64'(ARSIZE), 64'h2);
    check_value("ARBURST", 64'(ARBURST), 64'h0);
    check_value("WLAST", 64'(WLAST), 64'h1);
    check_value("BREADY", 64'(BREADY), 64'h1);
    check_value("RREADY", 64'(RREADY), 64'h1);
  endtask

  task automatic do_store(input logic [1:0] thr, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] data);
    logic [7:0] strb;
    aw_id_q.delete();
    aw_addr_q.delete();
    w_data_q.delete();
    w_strb_q.delete();
    issue(thr, 1'b1, addr, mask, data, 3'd0);
    idle();
    wait_release(4'b0001 << thr);
    // The word's byte lanes start at its byte offset within the 8-byte beat
    strb = 8'(mask) << {addr[2], 2'b00};
    assert (aw_id_q.size() == 1 && w_data_q.size() == 1)
    else
    begin
      $display("Store did not produce exactly one AW and one W beat");
      stop_run();
    end
    assert (aw_addr_q[0] == addr)
    else
    begin
      $display("Mismatch AWADDR: got %h, expected %h", aw_addr_q[0], addr);
      stop_run();
    end
    assert (aw_id_q[0] == thr)
    else
    begin
      $display("Mismatch AWID: got %h, expected %h", aw_id_q[0], thr);
      stop_run();
    end
    assert (w_data_q[0] == {data, data})
    else
    begin
      $display("Mismatch WDATA: got %h, expected %h", w_data_q[0], {data, data});
      stop_run();
    end
    assert (w_strb_q[0] == strb)
    else
    begin
      $display("Mismatch WSTRB: got %h, expected %h", w_strb_q[0], strb);
      stop_run();
    end
  endtask

  task automatic do_load(input logic [1:0] thr, input logic [31:0] addr,
                         input logic [3:0] mask, input logic [2:0] sel);
    issue(thr, 1'b0, addr, mask, 32'h0, sel);
    idle();
    wait_release(4'b0001 << thr);
    wait_loads(1);
    check_load(thr);
  endtask

  task automatic test_loads();
    do_store(2'd2, 32'h0000_3000, 4'hf, 32'h8bad_f00d);
    do_store(2'd2, 32'h0000_3004, 4'hf, 32'hc0ff_ee42);
    for (int a = 0; a < 2; a++)
      for (int i = 0; i < 7; i++)
        do_load(2'd2, 32'h0000_3000 + 32'(a) * 4, mask_set[i], 3'(i));
  endtask

  // All threads pend together and the slave answers in descending ID order
  task automatic test_mixed();
    hold_count    = 4;
    reverse_order = 1'b1;
    issue(2'd0, 1'b0, 32'h0000_4000, 4'hf, 32'h0, 3'd1);
    issue(2'd1, 1'b1, 32'h0000_4108, 4'hf, 32'h1234_5678, 3'd0);
    issue(2'd2, 1'b0, 32'h0000_4204, 4'h3, 32'h0, 3'd5);
    issue(2'd3, 1'b1, 32'h0000_430c, 4'h8, 32'hff00_aa55, 3'd0);
    idle();
    wait_release(4'hf);
    wait_loads(2);
    check_load(2'd0);
    check_load(2'd2);
    hold_count    = 1;
    reverse_order = 1'b0;
  endtask

  task automatic test_backpressure();
    logic [3:0] rd_m;
    logic       wr;
    ready_pct = 40;
    for (int r = 0; r < 8; r++)
    begin
      rd_m = '0;
      for (int t = 0; t < 4; t++)
      begin
        wr = 1'($urandom_range(1, 0));
        rd_m[t] = !wr;
        issue(2'(t), wr, 32'h0000_8000 + 32'(t) * 32'h100 + 32'($urandom_range(7, 0)) * 4,
              mask_set[$urandom_range(6, 0)], $urandom(), 3'($urandom_range(7, 0)));
      end
      idle();
      wait_release(4'hf);
      wait_loads($countones(rd_m));
      for (int t = 0; t < 4; t++)
        if (rd_m[t])
          check_load(2'(t));
    end
    ready_pct = 100;
  endtask

  initial
  begin
    void'($urandom(SEED));
    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    test_reset();
    do_store(2'd1, 32'h0000_2014, 4'b0110, 32'hdead_beef);
    do_store(2'd1, 32'h0000_2018, 4'hf, 32'h0bad_cafe);
    test_loads();
    test_mixed();
    test_backpressure();
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- tests/axi_lsu_asserts.sv
//==========================================================================
// Bound checks for the load/store unit
// AXI valid and payload stability under back-pressure and the stall rule
//==========================================================================

`timescale 1ns/1ps

module axi_lsu_asserts
  import axi_bus_pkg::*, lsu_core_pkg::*;
(
  input logic                   CLK,
  input logic                   RST,
  input logic                   AWVALID,
  input logic                   AWREADY,
  input logic [AXI_ID_W-1:0]    AWID,
  input logic [AXI_ADDR_W-1:0]  AWADDR,
  input logic                   WVALID,
  input logic                   WREADY,
  input logic [AXI_ID_W-1:0]    WID,
  input logic [AXI_DATA_W-1:0]  WDATA,
  input logic [AXI_STRB_W-1:0]  WSTRB,
  input logic                   ARVALID,
  input logic                   ARREADY,
  input logic [AXI_ID_W-1:0]    ARID,
  input logic [AXI_ADDR_W-1:0]  ARADDR,
  input logic                   BVALID,
  input logic [AXI_ID_W-1:0]    BID,
  input logic                   RVALID,
  input logic                   RLAST,
  input logic [AXI_ID_W-1:0]    RID,
  input logic [NUM_THREADS-1:0] stall,
  input logic [NUM_THREADS-1:0] pending_wr,
  input logic [NUM_THREADS-1:0] pending_rd
);

  aw_hold: assert property (@(posedge CLK) disable iff (RST)
    AWVALID && !AWREADY |=> AWVALID && $stable(AWADDR) && $stable(AWID))
    else $error("AW channel changed while AWREADY was low");

  w_hold: assert property (@(posedge CLK) disable iff (RST)
    WVALID && !WREADY |=> WVALID && $stable(WDATA) && $stable(WSTRB) && $stable(WID))
    else $error("W channel changed while WREADY was low");

  ar_hold: assert property (@(posedge CLK) disable iff (RST)
    ARVALID && !ARREADY |=> ARVALID && $stable(ARADDR) && $stable(ARID))
    else $error("AR channel changed while ARREADY was low");

  // A stalled thread with both pending bits low can only be in the cycle
  // right after its own B or R response
  for (genvar i = 0; i < NUM_THREADS; i++)
  begin : g_stall
    stall_rule: assert property (@(posedge CLK) disable iff (RST)
      stall[i] && !pending_wr[i] && !pending_rd[i] |->
        $past(BVALID && BID == AXI_ID_W'(i) || RVALID && RLAST && RID == AXI_ID_W'(i)))
      else $error("Stall set for a thread with no pending request");
  end

endmodule

bind axi_lsu axi_lsu_asserts u_asserts (
  .CLK        (CLK),
  .RST        (RST),
  .AWVALID    (AWVALID),
  .AWREADY    (AWREADY),
  .AWID       (AWID),
  .AWADDR     (AWADDR),
  .WVALID     (WVALID),
  .WREADY     (WREADY),
  .WID        (WID),
  .WDATA      (WDATA),
  .WSTRB      (WSTRB),
  .ARVALID    (ARVALID),
  .ARREADY    (ARREADY),
  .ARID       (ARID),
  .ARADDR     (ARADDR),
  .BVALID     (BVALID),
  .BID        (BID),
  .RVALID     (RVALID),
  .RLAST      (RLAST),
  .RID        (RID),
  .stall      (stall),
  .pending_wr (pending_wr),
  .pending_rd (pending_rd)
);

//--- design/axi_lsu.sv
//==========================================================================
// AXI load/store unit for a four-thread barrel core
// Connects the thread slots, the write and read engines and the load
// formatter between the core and a single-beat AXI3 master port
//==========================================================================

`timescale 1ns/1ps

module axi_lsu
  import axi_bus_pkg::*, lsu_core_pkg::*;
#(
  parameter int SLICE_OFFSET = 2
)
(
  input  logic                   CLK,
  input  logic                   RST,

  // Core requests and thread stall
  input  logic [SLICE_W-1:0]     slice,
  input  logic                   req_cs,
  input  logic                   req_wr,
  input  logic [AXI_ADDR_W-1:0]  req_addr,
  input  logic [CORE_MASK_W-1:0] req_mask,
  input  logic [CORE_DATA_W-1:0] req_data,
  input  logic [REG_SEL_W-1:0]   req_sel,
  output logic [NUM_THREADS-1:0] stall,

  // Load return to the register file
  output logic                   load_vld,
  output logic [SLICE_W-1:0]     load_slice,
  output logic [REG_SEL_W-1:0]   load_sel,
  output logic [CORE_DATA_W-1:0] load_data,

  output logic [AXI_ID_W-1:0]    AWID,
  output logic [AXI_ADDR_W-1:0]  AWADDR,
  output logic [AXI_LEN_W-1:0]   AWLEN,
  output logic [2:0]             AWSIZE,
  output logic [1:0]             AWBURST,
  output logic                   AWVALID,
  input  logic                   AWREADY,

  output logic [AXI_ID_W-1:0]    WID,
  output logic [AXI_DATA_W-1:0]  WDATA,
  output logic [AXI_STRB_W-1:0]  WSTRB,
  output logic                   WLAST,
  output logic                   WVALID,
  input  logic                   WREADY,

  input  logic [AXI_ID_W-1:0]    BID,
  input  logic                   BVALID,
  output logic                   BREADY,

  output logic [AXI_ID_W-1:0]    ARID,
  output logic [AXI_ADDR_W-1:0]  ARADDR,
  output logic [AXI_LEN_W-1:0]   ARLEN,
  output logic [2:0]             ARSIZE,
  output logic [1:0]             ARBURST,
  output logic                   ARVALID,
  input  logic                   ARREADY,

  input  logic [AXI_ID_W-1:0]    RID,
  input  logic [AXI_DATA_W-1:0]  RDATA,
  input  logic                   RLAST,
  input  logic                   RVALID,
  output logic                   RREADY
);

  logic [NUM_THREADS-1:0] pending_wr;
  logic [NUM_THREADS-1:0] pending_rd;
  logic [NUM_THREADS-1:0] wr_done;
  logic [NUM_THREADS-1:0] rd_done;
  logic [AXI_ADDR_W-1:0]  slot_addr [NUM_THREADS];
  logic [CORE_MASK_W-1:0] slot_mask [NUM_THREADS];
  logic [CORE_DATA_W-1:0] slot_data [NUM_THREADS];
  logic [REG_SEL_W-1:0]   slot_sel  [NUM_THREADS];

  // Single-beat word transfers only, responses are always accepted
  assign AWLEN   = AXI_LEN_SINGLE;
  assign AWSIZE  = AXI_SIZE_WORD;
  assign AWBURST = AXI_BURST_FIXED;
  assign ARLEN   = AXI_LEN_SINGLE;
  assign ARSIZE  = AXI_SIZE_WORD;
  assign ARBURST = AXI_BURST_FIXED;
  assign WLAST   = 1'b1;
  assign BREADY  = 1'b1;
  assign RREADY  = 1'b1;

  lsu_thread_slots #(
    .SLICE_OFFSET (SLICE_OFFSET)
  ) u_slots (
    .CLK        (CLK),
    .RST        (RST),
    .slice      (slice),
    .req_cs     (req_cs),
    .req_wr     (req_wr),
    .req_addr   (req_addr),
    .req_mask   (req_mask),
    .req_data   (req_data),
    .req_sel    (req_sel),
    .wr_done    (wr_done),
    .rd_done    (rd_done),
    .pending_wr (pending_wr),
    .pending_rd (pending_rd),
    .stall      (stall),
    .slot_addr  (slot_addr),
    .slot_mask  (slot_mask),
    .slot_data  (slot_data),
    .slot_sel   (slot_sel)
  );

  lsu_write_engine u_wr (
    .CLK        (CLK),
    .RST        (RST),
    .pending_wr (pending_wr),
    .slot_addr  (slot_addr),
    .slot_mask  (slot_mask),
    .slot_data  (slot_data),
    .AWID       (AWID),
    .AWADDR     (AWADDR),
    .AWVALID    (AWVALID),
    .AWREADY    (AWREADY),
    .WID        (WID),
    .WDATA      (WDATA),
    .WSTRB      (WSTRB),
    .WVALID     (WVALID),
    .WREADY     (WREADY),
    .BVALID     (BVALID),
    .BID        (BID),
    .wr_done    (wr_done)
  );

  lsu_read_engine u_rd (
    .CLK        (CLK),
    .RST        (RST),
    .pending_rd (pending_rd),
    .slot_addr  (slot_addr),
    .ARID       (ARID),
    .ARADDR     (ARADDR),
    .ARVALID    (ARVALID),
    .ARREADY    (ARREADY),
    .RVALID     (RVALID),
    .RLAST      (RLAST),
    .RID        (RID),
    .rd_done    (rd_done)
  );

  lsu_load_format u_fmt (
    .CLK        (CLK),
    .RST        (RST),
    .RVALID     (RVALID),
    .RID        (RID),
    .RDATA      (RDATA),
    .slot_addr  (slot_addr),
    .slot_mask  (slot_mask),
    .slot_sel   (slot_sel),
    .load_vld   (load_vld),
    .load_slice (load_slice),
    .load_sel   (load_sel),
    .load_data  (load_data)
  );

endmodule

//--- design/lsu_load_format.sv
//==========================================================================
// Load formatter
// Registers the R beat, extracts the addressed byte, halfword or word and
// returns it zero-extended to the register file
//==========================================================================

`timescale 1ns/1ps

module lsu_load_format
  import axi_bus_pkg::*, lsu_core_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,

  input  logic                   RVALID,
  input  logic [AXI_ID_W-1:0]    RID,
  input  logic [AXI_DATA_W-1:0]  RDATA,

  input  logic [AXI_ADDR_W-1:0]  slot_addr [NUM_THREADS],
  input  logic [CORE_MASK_W-1:0] slot_mask [NUM_THREADS],
  input  logic [REG_SEL_W-1:0]   slot_sel  [NUM_THREADS],

  output logic                   load_vld,
  output logic [SLICE_W-1:0]     load_slice,
  output logic [REG_SEL_W-1:0]   load_sel,
  output logic [CORE_DATA_W-1:0] load_data
);

  logic                   rvalid_q;
  logic [AXI_ID_W-1:0]    rid_q;
  logic [AXI_DATA_W-1:0]  rdata_q;
  logic [CORE_DATA_W-1:0] lane;
  logic [CORE_MASK_W-1:0] mask;
  logic [CORE_DATA_W-1:0] field;

  // First stage holds the beat
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= RVALID;
  end

  always_ff @(posedge CLK)
  begin
    rid_q   <= RID;
    rdata_q <= RDATA;
  end

  // The slot of the returning thread still holds its address and mask
  assign lane = slot_addr[rid_q][2] ? rdata_q[63:32] : rdata_q[31:0];
  assign mask = slot_mask[rid_q];

  always_comb
  begin
    case (mask)
      4'b0001:      field = CORE_DATA_W'(lane[7:0]);
      4'b0010:      field = CORE_DATA_W'(lane[15:8]);
      4'b0100:      field = CORE_DATA_W'(lane[23:16]);
      4'b1000:      field = CORE_DATA_W'(lane[31:24]);
      MASK_HALF_LO: field = CORE_DATA_W'(lane[15:0]);
      MASK_HALF_HI: field = CORE_DATA_W'(lane[31:16]);
      default:      field = lane;
    endcase
  end

  // Second stage drives the register file write port
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      load_vld <= 1'b0;
    else
      load_vld <= rvalid_q;
  end

  always_ff @(posedge CLK)
  begin
    load_slice <= SLICE_W'(rid_q);
    load_sel   <= slot_sel[rid_q];
    load_data  <= field;
  end

endmodule

//--- design/lsu_read_engine.sv
//==========================================================================
// Read engine of the load/store unit
// Round-robin AR issue over the threads with a pending load
//==========================================================================

`timescale 1ns/1ps

module lsu_read_engine
  import axi_bus_pkg::*, lsu_core_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,

  input  logic [NUM_THREADS-1:0] pending_rd,
  input  logic [AXI_ADDR_W-1:0]  slot_addr [NUM_THREADS],

  output logic [AXI_ID_W-1:0]    ARID,
  output logic [AXI_ADDR_W-1:0]  ARADDR,
  output logic                   ARVALID,
  input  logic                   ARREADY,

  input  logic                   RVALID,
  input  logic                   RLAST,
  input  logic [AXI_ID_W-1:0]    RID,

  output logic [NUM_THREADS-1:0] rd_done
);

  typedef enum logic {RD_SCAN, RD_ADDR} rd_state_t;

  rd_state_t              state;
  logic [SLICE_W-1:0]     cur;
  logic [NUM_THREADS-1:0] sent;
  logic [NUM_THREADS-1:0] sent_set;

  always_comb
  begin
    rd_done = '0;
    if (RVALID && RLAST)
      rd_done[RID] = 1'b1;
  end

  always_comb
  begin
    sent_set = '0;
    if (state == RD_ADDR && ARREADY)
      sent_set[cur] = 1'b1;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      state   <= RD_SCAN;
      cur     <= '0;
      sent    <= '0;
      ARVALID <= 1'b0;
    end
    else
    begin
      sent <= (sent | sent_set) & ~rd_done;
      case (state)
        RD_SCAN:
          if (pending_rd[cur] && !sent[cur])
          begin
            state   <= RD_ADDR;
            ARVALID <= 1'b1;
          end
          else
            cur <= cur + 1'b1;
        default:
          if (ARREADY)
          begin
            state   <= RD_SCAN;
            cur     <= cur + 1'b1;
            ARVALID <= 1'b0;
          end
      endcase
    end
  end

  // Address and ID follow the thread under scan until AR is raised
  always_ff @(posedge CLK)
  begin
    if (state == RD_SCAN)
    begin
      ARID   <= AXI_ID_W'(cur);
      ARADDR <= slot_addr[cur];
    end
  end

endmodule

//--- design/lsu_write_engine.sv
//==========================================================================
// Write engine of the load/store unit
// Scans the threads in round-robin order and issues one AW and W beat for
// each pending store, then waits for the matching B response
//==========================================================================

`timescale 1ns/1ps

module lsu_write_engine
  import axi_bus_pkg::*, lsu_core_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,

  input  logic [NUM_THREADS-1:0] pending_wr,
  input  logic [AXI_ADDR_W-1:0]  slot_addr [NUM_THREADS],
  input  logic [CORE_MASK_W-1:0] slot_mask [NUM_THREADS],
  input  logic [CORE_DATA_W-1:0] slot_data [NUM_THREADS],

  output logic [AXI_ID_W-1:0]    AWID,
  output logic [AXI_ADDR_W-1:0]  AWADDR,
  output logic                   AWVALID,
  input  logic                   AWREADY,

  output logic [AXI_ID_W-1:0]    WID,
  output logic [AXI_DATA_W-1:0]  WDATA,
  output logic [AXI_STRB_W-1:0]  WSTRB,
  output logic                   WVALID,
  input  logic                   WREADY,

  input  logic                   BVALID,
  input  logic [AXI_ID_W-1:0]    BID,

  output logic [NUM_THREADS-1:0] wr_done
);

  typedef enum logic [1:0] {WR_SCAN, WR_ADDR, WR_DATA} wr_state_t;

  wr_state_t              state;
  logic [SLICE_W-1:0]     cur;
  logic [NUM_THREADS-1:0] sent;
  logic [NUM_THREADS-1:0] sent_set;

  // Any response releases the thread named by BID
  always_comb
  begin
    wr_done = '0;
    if (BVALID)
      wr_done[BID] = 1'b1;
  end

  always_comb
  begin
    sent_set = '0;
    if (state == WR_DATA && WREADY)
      sent_set[cur] = 1'b1;
  end

  // A sent thread is skipped by the scan until its B response comes back
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      sent <= '0;
    else
      sent <= (sent | sent_set) & ~wr_done;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      state   <= WR_SCAN;
      cur     <= '0;
      AWVALID <= 1'b0;
      WVALID  <= 1'b0;
    end
    else
    begin
      case (state)
        WR_SCAN:
          if (pending_wr[cur] && !sent[cur])
          begin
            state   <= WR_ADDR;
            AWVALID <= 1'b1;
          end
          else
            cur <= cur + 1'b1;
        WR_ADDR:
          if (AWREADY)
          begin
            state   <= WR_DATA;
            AWVALID <= 1'b0;
            WVALID  <= 1'b1;
          end
        WR_DATA:
          if (WREADY)
          begin
            state  <= WR_SCAN;
            cur    <= cur + 1'b1;
            WVALID <= 1'b0;
          end
        default:
          state <= WR_SCAN;
      endcase
    end
  end

  // Payload is loaded as the matching valid rises and then held stable
  always_ff @(posedge CLK)
  begin
    if (state == WR_SCAN)
    begin
      AWID   <= AXI_ID_W'(cur);
      AWADDR <= slot_addr[cur];
    end
    if (state == WR_ADDR && AWREADY)
    begin
      WID   <= AXI_ID_W'(cur);
      // The core word goes on both halves, the strobes pick the live one
      WDATA <= {slot_data[cur], slot_data[cur]};
      if (slot_addr[cur][2])
        WSTRB <= {slot_mask[cur], {CORE_MASK_W{1'b0}}};
      else
        WSTRB <= {{CORE_MASK_W{1'b0}}, slot_mask[cur]};
    end
  end

endmodule

//--- design/lsu_thread_slots.sv
//==========================================================================
// Thread slots of the load/store unit
// Decodes core requests into per-thread slots, tracks pending reads and
// writes and stalls each thread until its bus response has arrived
//==========================================================================

`timescale 1ns/1ps

module lsu_thread_slots
  import axi_bus_pkg::*, lsu_core_pkg::*;
#(
  parameter int SLICE_OFFSET = 2
)
(
  input  logic                   CLK,
  input  logic                   RST,

  input  logic [SLICE_W-1:0]     slice,
  input  logic                   req_cs,
  input  logic                   req_wr,
  input  logic [AXI_ADDR_W-1:0]  req_addr,
  input  logic [CORE_MASK_W-1:0] req_mask,
  input  logic [CORE_DATA_W-1:0] req_data,
  input  logic [REG_SEL_W-1:0]   req_sel,

  input  logic [NUM_THREADS-1:0] wr_done,
  input  logic [NUM_THREADS-1:0] rd_done,

  output logic [NUM_THREADS-1:0] pending_wr,
  output logic [NUM_THREADS-1:0] pending_rd,
  output logic [NUM_THREADS-1:0] stall,

  output logic [AXI_ADDR_W-1:0]  slot_addr [NUM_THREADS],
  output logic [CORE_MASK_W-1:0] slot_mask [NUM_THREADS],
  output logic [CORE_DATA_W-1:0] slot_data [NUM_THREADS],
  output logic [REG_SEL_W-1:0]   slot_sel  [NUM_THREADS]
);

  logic [SLICE_W-1:0]     req_thr;
  logic [NUM_THREADS-1:0] wr_req;
  logic [NUM_THREADS-1:0] rd_req;

  // The slice counter runs ahead of the thread that owns the request,
  // the wrap past the last thread comes from the truncation
  assign req_thr = slice + SLICE_W'(SLICE_OFFSET);

  always_comb
  begin
    wr_req = '0;
    rd_req = '0;
    if (req_cs)
    begin
      if (req_wr)
        wr_req[req_thr] = 1'b1;
      else
        rd_req[req_thr] = 1'b1;
    end
  end

  // A thread is stalled while its request sits in the slot, so the
  // slot cannot be overwritten before the transaction is finished
  always_ff @(posedge CLK)
  begin
    if (req_cs)
    begin
      slot_addr[req_thr] <= req_addr;
      slot_mask[req_thr] <= req_mask;
      slot_data[req_thr] <= req_data;
      slot_sel[req_thr]  <= req_sel;
    end
  end

  // Pending bits set on the request and clear on the done pulse
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pending_wr <= '0;
      pending_rd <= '0;
      stall      <= '0;
    end
    else
    begin
      pending_wr <= (pending_wr & ~wr_done) | wr_req;
      pending_rd <= (pending_rd & ~rd_done) | rd_req;
      // Stall trails the pending bits by one clock
      stall      <= pending_wr | pending_rd;
    end
  end

endmodule

//--- design/lsu_core_pkg.sv
//==========================================================================
// Core-side package of the load/store unit
// Thread count and the widths of the fields held in each thread slot
//==========================================================================

package lsu_core_pkg;

  // Barrel core with four hardware threads
  localparam int NUM_THREADS = 4;

  // Width of the slice counter and of a thread index
  localparam int SLICE_W = 2;

  // Core data word and its byte mask
  localparam int CORE_DATA_W = 32;
  localparam int CORE_MASK_W = 4;

  // Destination register select of a load
  localparam int REG_SEL_W = 3;

  // A byte mask covering the whole word
  localparam logic [CORE_MASK_W-1:0] MASK_WORD = '1;

  // Halfword masks within a word
  localparam logic [CORE_MASK_W-1:0] MASK_HALF_LO = 4'b0011;
  localparam logic [CORE_MASK_W-1:0] MASK_HALF_HI = 4'b1100;

endpackage

//--- design/axi_bus_pkg.sv
//==========================================================================
// AXI bus package
// Widths, response codes and fixed transfer attributes for the AXI3
// master port of the load/store bus unit
//==========================================================================

package axi_bus_pkg;

  // Bus widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;

  // The transaction ID is the thread number
  localparam int AXI_ID_W = 2;

  // AXI3 burst length field
  localparam int AXI_LEN_W = 4;

  // Response code that marks a good transfer
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // Every transfer is a single 4-byte beat with a fixed burst
  localparam logic [AXI_LEN_W-1:0] AXI_LEN_SINGLE = '0;
  localparam logic [2:0] AXI_SIZE_WORD = 3'd2;
  localparam logic [1:0] AXI_BURST_FIXED = 2'b00;

endpackage
